// ==== source/fe_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared word type, opcode encodings and sizing constants for the RV32I
// fetch/execute front end. Blocks refer to these as fe_pkg::name.
////////////////////////////////////////////////////////////////////////////

package fe_pkg;

  typedef logic [31:0] word_t;                     // pc, instruction or data word.

  // major opcodes that the execute stage acts on; all others retire as no-ops.
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,                        // load upper immediate.
    OP_IMM    = 7'b0010011,                        // register-immediate ALU group.
    OP_JAL    = 7'b1101111,                        // jump and link.
    OP_BRANCH = 7'b1100011                         // conditional branches.
  } opcode_t;

  localparam word_t RESET_PC = 32'h0000_0200;      // first fetch address out of reset.

  ////////////////////////////////////////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////////////////////////////////////////
  localparam int RAM_WORDS = 256;                  // addresses wrap at 1 KiB.
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);    // index is pc[9:2].
  localparam int RAM_WAIT  = 2;                    // busy cycles after a new address.
  localparam int RAM_CNT_W = $clog2(RAM_WAIT + 1); // wait counter reaches RAM_WAIT.

  ////////////////////////////////////////////////////////////////////////////
  // branch target buffer
  ////////////////////////////////////////////////////////////////////////////
  localparam int BTB_ENTRIES = 16;                 // direct mapped.
  localparam int BTB_IDX_W   = 4;                  // index is pc[5:2].
  localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2; // rest of the pc above the index.

  // low bit of each instruction field.
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;

  // funct3 codes that are decoded.
  localparam logic [2:0] FUNCT3_ADDI = 3'b000;     // only ADDI of the OP_IMM group.
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;     // branch if equal.
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;     // branch if not equal.

endpackage

// ==== source/fetch_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Fetch stage. Holds the PC, picks the next PC, reads the big-endian
// instruction RAM and loads the fetch/execute pipeline register.
////////////////////////////////////////////////////////////////////////////

module fetch_stage (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          pc_en,
  input  logic          npc_sel,
  input  logic          if_ex_flush,
  input  logic          if_ex_stall,
  input  fe_pkg::word_t brj_addr,
  input  fe_pkg::word_t target_addr,
  input  logic          predict_taken,
  input  fe_pkg::word_t iram_rdata,
  input  logic          iram_busy,
  output fe_pkg::word_t iram_addr,
  output fe_pkg::word_t current_pc,
  output logic          i_ram_busy,
  output logic          mal_insn,
  output logic          fe_valid,
  output fe_pkg::word_t fe_pc,
  output fe_pkg::word_t fe_pc4,
  output fe_pkg::word_t fe_instr,
  output logic          fe_prediction
);

  fe_pkg::word_t pc, pc4, npc, instr;

  ////////////////////////////////////////////////////////////////////////////
  // program counter
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= fe_pkg::RESET_PC;                     // start of the loaded program.
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign pc4 = pc + 32'd4;
  // a resolved redirect beats the prediction, which beats sequential flow.
  assign npc = npc_sel ? brj_addr : (predict_taken ? target_addr : pc4);

  assign current_pc = pc;                         // predictor lookup address.
  assign iram_addr  = pc;
  assign i_ram_busy = iram_busy;                  // passed on to the hazard unit.
  assign mal_insn   = (pc[1:0] != 2'b00);         // fetch address not word aligned.

  // the RAM holds words big-endian, so reverse the bytes.
  assign instr = {iram_rdata[7:0], iram_rdata[15:8], iram_rdata[23:16], iram_rdata[31:24]};

  ////////////////////////////////////////////////////////////////////////////
  // fetch/execute register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fe_valid <= 1'b0;
    end else if (if_ex_flush) begin
      fe_valid <= 1'b0;                           // bubble into execute.
    end else if (!if_ex_stall) begin
      fe_valid <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!if_ex_flush && !if_ex_stall) begin
      fe_pc         <= pc;
      fe_pc4        <= pc4;
      fe_instr      <= instr;
      fe_prediction <= predict_taken;             // execute checks this against the outcome.
    end
  end

endmodule

// ==== source/branch_predictor.sv ====
////////////////////////////////////////////////////////////////////////////
// Direct-mapped, tagged branch target buffer with 2-bit counters. Looked
// up combinationally by the fetch PC, updated by execute one edge later.
////////////////////////////////////////////////////////////////////////////

module branch_predictor (
  input  logic          CLK,
  input  logic          nRST,
  input  fe_pkg::word_t current_pc,
  input  logic          update_en,
  input  logic          update_taken,
  input  fe_pkg::word_t update_pc,
  input  fe_pkg::word_t update_target,
  output logic          predict_taken,
  output fe_pkg::word_t target_addr
);

  logic                         valid  [fe_pkg::BTB_ENTRIES];
  logic [fe_pkg::BTB_TAG_W-1:0] tag    [fe_pkg::BTB_ENTRIES];
  fe_pkg::word_t                target [fe_pkg::BTB_ENTRIES];
  logic [1:0]                   count  [fe_pkg::BTB_ENTRIES];

  logic [fe_pkg::BTB_IDX_W-1:0] rd_idx, up_idx;
  logic [fe_pkg::BTB_TAG_W-1:0] rd_tag, up_tag;
  logic                         rd_hit, up_hit;

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////
  assign rd_idx = current_pc[fe_pkg::BTB_IDX_W+1:2];
  assign rd_tag = current_pc[31:fe_pkg::BTB_IDX_W+2];
  assign rd_hit = valid[rd_idx] && (tag[rd_idx] == rd_tag);

  assign predict_taken = rd_hit && count[rd_idx][1]; // counter at 2 or 3.
  assign target_addr   = target[rd_idx];

  ////////////////////////////////////////////////////////////////////////////
  // update
  ////////////////////////////////////////////////////////////////////////////
  assign up_idx = update_pc[fe_pkg::BTB_IDX_W+1:2];
  assign up_tag = update_pc[31:fe_pkg::BTB_IDX_W+2];
  assign up_hit = valid[up_idx] && (tag[up_idx] == up_tag);

  // a taken miss claims the entry.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < fe_pkg::BTB_ENTRIES; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (update_en && !up_hit && update_taken) begin
      valid[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (update_en) begin
      if (up_hit) begin
        target[up_idx] <= update_target;
        if (update_taken && count[up_idx] != 2'd3) begin
          count[up_idx] <= count[up_idx] + 2'd1;     // saturate at strongly taken.
        end else if (!update_taken && count[up_idx] != 2'd0) begin
          count[up_idx] <= count[up_idx] - 2'd1;
        end
      end else if (update_taken) begin
        tag[up_idx]    <= up_tag;                  // a new entry starts weakly taken.
        target[up_idx] <= update_target;
        count[up_idx]  <= 2'd2;
      end
    end
  end

endmodule

// ==== source/hazard_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Pipeline control. Drives the PC enable, next-PC select and the flush and
// stall of the fetch/execute register; latches a misaligned-fetch fault.
////////////////////////////////////////////////////////////////////////////

module hazard_unit (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          i_ram_busy,
  input  logic          mal_insn,
  input  logic          mispredict,
  input  fe_pkg::word_t fault_addr,
  output logic          pc_en,
  output logic          npc_sel,
  output logic          if_ex_flush,
  output logic          if_ex_stall,
  output logic          fault,
  output fe_pkg::word_t fault_pc
);

  logic halt;

  // the fault is sticky until reset and records the offending pc.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fault    <= 1'b0;
      fault_pc <= '0;
    end else if (mal_insn && !fault) begin
      fault    <= 1'b1;
      fault_pc <= fault_addr;
    end
  end

  assign halt = fault || mal_insn;                // fetch stops in the faulting cycle.

  assign npc_sel     = mispredict;                // take the resolved address.
  assign pc_en       = !halt && (mispredict || !i_ram_busy); // redirect beats busy.
  assign if_ex_flush = halt || mispredict || i_ram_busy;     // a bubble replaces the stale word.
  assign if_ex_stall = fault;

endmodule

// ==== source/instr_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// Word-addressed instruction RAM, loaded through the program port. Each
// new read address costs RAM_WAIT busy cycles before rdata is valid.
////////////////////////////////////////////////////////////////////////////

module instr_ram (
  input  logic          CLK,
  input  logic          nRST,
  input  fe_pkg::word_t addr,
  input  logic          prog_wen,
  input  fe_pkg::word_t prog_addr,
  input  fe_pkg::word_t prog_wdata,
  output fe_pkg::word_t rdata,
  output logic          busy
);

  fe_pkg::word_t                mem [fe_pkg::RAM_WORDS];
  fe_pkg::word_t                last_addr;      // address the counter belongs to.
  logic [fe_pkg::RAM_CNT_W-1:0] wait_cnt;       // cycles spent on last_addr.
  logic                         addr_changed;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (prog_wen) begin
      mem[prog_addr[fe_pkg::RAM_IDX_W+1:2]] <= prog_wdata;  // word stored as given.
    end
  end

  assign rdata = mem[addr[fe_pkg::RAM_IDX_W+1:2]];    // valid once busy is low.

  ////////////////////////////////////////////////////////////////////////////
  // wait states
  ////////////////////////////////////////////////////////////////////////////
  assign addr_changed = (addr != last_addr);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_addr <= fe_pkg::RESET_PC;                   // so the reset pc waits too.
      wait_cnt  <= '0;
    end else if (addr_changed) begin
      last_addr <= addr;
      wait_cnt  <= fe_pkg::RAM_CNT_W'(1);              // the change cycle was the first.
    end else if (wait_cnt < fe_pkg::RAM_WAIT) begin
      wait_cnt  <= wait_cnt + 1'b1;
    end
  end

  // busy in the cycle of the change and until the count is complete.
  assign busy = addr_changed || (wait_cnt < fe_pkg::RAM_WAIT);

endmodule

// ==== source/execute_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Reduced execute stage: ADDI, LUI, JAL, BEQ and BNE on a 32-entry register
// file. Resolves control flow, trains the predictor and reports retires.
////////////////////////////////////////////////////////////////////////////

module execute_stage (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          fe_valid,
  input  fe_pkg::word_t fe_pc,
  input  fe_pkg::word_t fe_pc4,
  input  fe_pkg::word_t fe_instr,
  input  logic          fe_prediction,
  output fe_pkg::word_t brj_addr,
  output logic          mispredict,
  output logic          update_en,
  output logic          update_taken,
  output fe_pkg::word_t update_pc,
  output fe_pkg::word_t update_target,
  output logic          retire_valid,
  output fe_pkg::word_t retire_pc,
  output logic [4:0]    retire_rd,
  output logic          retire_wen,
  output fe_pkg::word_t retire_value
);

  fe_pkg::opcode_t opcode;
  logic [2:0]      funct3;
  logic [4:0]      rd, rs1, rs2;
  fe_pkg::word_t   rs1_val, rs2_val;
  fe_pkg::word_t   imm_i, imm_u, imm_j, imm_b;
  fe_pkg::word_t   result, target;
  logic            wen, taken, is_ctrl, wr_en;
  fe_pkg::word_t   regs [32];               // x0 entry is never read.

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////
  assign opcode = fe_pkg::opcode_t'(fe_instr[6:0]);
  assign funct3 = fe_instr[fe_pkg::FUNCT3_LSB +: 3];
  assign rd     = fe_instr[fe_pkg::RD_LSB +: 5];
  assign rs1    = fe_instr[fe_pkg::RS1_LSB +: 5];
  assign rs2    = fe_instr[fe_pkg::RS2_LSB +: 5];

  assign imm_i = {{20{fe_instr[31]}}, fe_instr[31:20]};
  assign imm_u = {fe_instr[31:12], 12'b0};
  assign imm_j = {{12{fe_instr[31]}}, fe_instr[19:12], fe_instr[20], fe_instr[30:21], 1'b0};
  assign imm_b = {{20{fe_instr[31]}}, fe_instr[7], fe_instr[30:25], fe_instr[11:8], 1'b0};

  assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads as zero.
  assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_comb begin
    wen     = 1'b0;
    result  = '0;                           // no-ops retire with a zero value.
    taken   = 1'b0;
    is_ctrl = 1'b0;
    target  = fe_pc + imm_b;
    case (opcode)
      fe_pkg::OP_IMM: begin
        if (funct3 == fe_pkg::FUNCT3_ADDI) begin
          wen    = 1'b1;
          result = rs1_val + imm_i;
        end
      end
      fe_pkg::OP_LUI: begin
        wen    = 1'b1;
        result = imm_u;
      end
      fe_pkg::OP_JAL: begin
        wen     = 1'b1;
        result  = fe_pc4;                   // link address.
        taken   = 1'b1;
        is_ctrl = 1'b1;
        target  = fe_pc + imm_j;
      end
      fe_pkg::OP_BRANCH: begin
        if (funct3 == fe_pkg::FUNCT3_BEQ) begin
          is_ctrl = 1'b1;
          taken   = (rs1_val == rs2_val);
        end else if (funct3 == fe_pkg::FUNCT3_BNE) begin
          is_ctrl = 1'b1;
          taken   = (rs1_val != rs2_val);
        end
      end
      default: ;                            // anything else is a no-op.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // resolution and predictor training
  ////////////////////////////////////////////////////////////////////////////
  // a taken prediction on a non-branch is also wrong and falls back to pc+4.
  assign mispredict    = fe_valid && (taken != fe_prediction);
  assign brj_addr      = taken ? target : fe_pc4;
  assign update_en     = fe_valid && is_ctrl;
  assign update_taken  = taken;
  assign update_pc     = fe_pc;
  assign update_target = target;

  ////////////////////////////////////////////////////////////////////////////
  // writeback and retire
  ////////////////////////////////////////////////////////////////////////////
  assign wr_en = wen && (rd != 5'd0);       // x0 stays zero.

  always_ff @(posedge CLK) begin
    if (fe_valid && wr_en) begin
      regs[rd] <= result;
    end
  end

  assign retire_valid = fe_valid;
  assign retire_pc    = fe_pc;
  assign retire_rd    = rd;
  assign retire_wen   = wr_en;
  assign retire_value = result;

endmodule

// ==== source/fetch_exec_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level of the two-stage front end. Connects fetch, predictor, hazard
// unit, instruction RAM and execute; exposes program load and retire.
////////////////////////////////////////////////////////////////////////////

module fetch_exec_top (
  input  logic          CLK,
  input  logic          nRST,
  input  logic          prog_wen,
  input  fe_pkg::word_t prog_addr,
  input  fe_pkg::word_t prog_wdata,
  output logic          retire_valid,
  output fe_pkg::word_t retire_pc,
  output logic [4:0]    retire_rd,
  output logic          retire_wen,
  output fe_pkg::word_t retire_value,
  output logic          fault,
  output fe_pkg::word_t fault_pc
);

  fe_pkg::word_t iram_addr, iram_rdata, current_pc, target_addr, brj_addr;
  fe_pkg::word_t fe_pc, fe_pc4, fe_instr, update_pc, update_target;
  logic          iram_busy, i_ram_busy, mal_insn, predict_taken, mispredict;
  logic          pc_en, npc_sel, if_ex_flush, if_ex_stall;
  logic          fe_valid, fe_prediction, update_en, update_taken;

  fetch_stage u_fetch (
    .CLK, .nRST, .pc_en, .npc_sel, .if_ex_flush, .if_ex_stall,
    .brj_addr, .target_addr, .predict_taken, .iram_rdata, .iram_busy,
    .iram_addr, .current_pc, .i_ram_busy, .mal_insn,
    .fe_valid, .fe_pc, .fe_pc4, .fe_instr, .fe_prediction
  );

  branch_predictor u_btb (
    .CLK, .nRST, .current_pc, .update_en, .update_taken,
    .update_pc, .update_target, .predict_taken, .target_addr
  );

  hazard_unit u_hazard (
    .CLK, .nRST, .i_ram_busy, .mal_insn, .mispredict,
    .fault_addr (current_pc),                  // the pc that failed alignment.
    .pc_en, .npc_sel, .if_ex_flush, .if_ex_stall, .fault, .fault_pc
  );

  instr_ram u_iram (
    .CLK, .nRST, .addr (iram_addr), .prog_wen, .prog_addr, .prog_wdata,
    .rdata (iram_rdata), .busy (iram_busy)
  );

  execute_stage u_exec (
    .CLK, .nRST, .fe_valid, .fe_pc, .fe_pc4, .fe_instr, .fe_prediction,
    .brj_addr, .mispredict, .update_en, .update_taken, .update_pc, .update_target,
    .retire_valid, .retire_pc, .retire_rd, .retire_wen, .retire_value
  );

endmodule

// ==== bench/tb_fetch_exec.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the fetch/execute front end. Loads the program from the
// stimulus file, runs it and checks every retire record and the fault.
////////////////////////////////////////////////////////////////////////////

module tb_fetch_exec;

  localparam string STIM_FILE    = "bench/fetch_stimulus.txt";
  localparam int    QUIET_CYCLES = 8;            // cycles after the fault that must stay idle.

  logic          CLK;
  logic          nRST;
  logic          prog_wen;
  fe_pkg::word_t prog_addr;
  fe_pkg::word_t prog_wdata;
  logic          retire_valid;
  fe_pkg::word_t retire_pc;
  logic [4:0]    retire_rd;
  logic          retire_wen;
  fe_pkg::word_t retire_value;
  logic          fault;
  fe_pkg::word_t fault_pc;

  fe_pkg::word_t load_addr [$];                  // program image, in file order.
  fe_pkg::word_t load_word [$];
  fe_pkg::word_t exp_pc    [$];                  // expected retire records, oldest first.
  logic [4:0]    exp_rd    [$];
  logic          exp_wen   [$];
  fe_pkg::word_t exp_value [$];
  fe_pkg::word_t exp_fault_pc;
  logic          fault_given;                    // the file held an F line.
  int            record_idx;
  int            cycle_count;
  int            cycle_limit;
  int            quiet_count;

  fetch_exec_top u_dut (
    .CLK, .nRST, .prog_wen, .prog_addr, .prog_wdata,
    .retire_valid, .retire_pc, .retire_rd, .retire_wen, .retire_value,
    .fault, .fault_pc
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;                      // period of 40.
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input fe_pkg::word_t expected,
                                 input fe_pkg::word_t actual);
    stop_with_failure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  // the RAM keeps the most significant byte at the lowest address.
  function automatic fe_pkg::word_t swap_bytes(input fe_pkg::word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus file
  ////////////////////////////////////////////////////////////////////////////
  task automatic read_stimulus();
    int            fd;
    int            n;
    string         line;
    byte           kind;
    fe_pkg::word_t f1, f2, f3, f4;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_with_failure("the stimulus file could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 1) begin
          kind = line.getc(0);                   // record type letter or a comment mark.
          n    = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f1, f2, f3, f4);
          case (kind)
            "P": begin
              load_addr.push_back(f1);
              load_word.push_back(f2);
            end
            "E": begin
              exp_pc.push_back(f1);
              exp_rd.push_back(f2[4:0]);
              exp_wen.push_back(f3[0]);
              exp_value.push_back(f4);
            end
            "F": begin
              exp_fault_pc = f1;
              fault_given  = 1'b1;
            end
            default: ;                           // comment lines carry no data.
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // retire checks
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_retire();
    string name;
    if (exp_pc.size() == 0) begin
      stop_with_failure($sformatf("unexpected retire at pc %h after the last record",
                                  retire_pc));
    end else begin
      name = $sformatf("record %0d", record_idx);
      assert (retire_pc == exp_pc[0])
        else report_mismatch({name, " pc"}, exp_pc[0], retire_pc);
      assert (retire_wen == exp_wen[0])
        else report_mismatch({name, " wen"}, 32'(exp_wen[0]), 32'(retire_wen));
      if (exp_wen[0]) begin                      // rd and value only mean something on a write.
        assert (retire_rd == exp_rd[0])
          else report_mismatch({name, " rd"}, 32'(exp_rd[0]), 32'(retire_rd));
        assert (retire_value == exp_value[0])
          else report_mismatch({name, " value"}, exp_value[0], retire_value);
      end
      void'(exp_pc.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_wen.pop_front());
      void'(exp_value.pop_front());
      record_idx++;
    end
  endtask

  // outputs settle after the rising edge, so they are read on the falling one.
  always @(negedge CLK) begin
    if (nRST) begin
      cycle_count++;
      assert (cycle_count <= cycle_limit)
        else stop_with_failure($sformatf("timeout: the run did not finish within %0d cycles",
                                         cycle_limit));
      if (retire_valid) begin
        check_retire();
      end
      if (fault) begin
        if (quiet_count == 0) begin              // first cycle with the fault set.
          assert (exp_pc.size() == 0)
            else stop_with_failure($sformatf("fault raised with %0d records not yet retired",
                                             exp_pc.size()));
          assert (fault_pc == exp_fault_pc)
            else report_mismatch("fault pc", exp_fault_pc, fault_pc);
        end
        quiet_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // program load, reset and end of run
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    nRST        = 1'b0;
    prog_wen    = 1'b0;
    prog_addr   = '0;
    prog_wdata  = '0;
    fault_given = 1'b0;
    record_idx  = 0;
    cycle_count = 0;
    quiet_count = 0;
    read_stimulus();
    cycle_limit = exp_pc.size() * (fe_pkg::RAM_WAIT + 3) + 100;  // worst case per record.
    assert (exp_pc.size() > 0 && fault_given)
      else stop_with_failure("the stimulus file holds no retire records or no fault line");
    foreach (load_addr[i]) begin
      @(posedge CLK);
      prog_wen   <= 1'b1;
      prog_addr  <= load_addr[i];
      prog_wdata <= swap_bytes(load_word[i]);    // stored big-endian.
    end
    @(posedge CLK);
    prog_wen <= 1'b0;
    repeat (4) @(posedge CLK);                   // reset held four cycles past the load.
    nRST <= 1'b1;
    wait (quiet_count == QUIET_CYCLES);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== bench/fetch_stimulus.txt ====
# P addr word: program word as the CPU executes it. E pc rd wen value: expected retire,
# rd and value are compared only when wen is 1. F pc: expected misaligned fetch address.
P 00000200 00500093
P 00000204 12345137
P 00000208 67810113
P 0000020C 00708013
P 00000210 00100193
P 00000214 00C0026F
P 00000218 06300293
P 0000021C 06300293
P 00000220 00300293
P 00000224 00000313
P 00000228 00230313
P 0000022C FFF28293
P 00000230 FE029CE3
P 00000234 00308463
P 00000238 00630463
P 0000023C 06300293
P 00000240 ABCDE3B7
P 00000244 FFF38413
P 00000248 006000EF
# straight-line code, an x0 write, then JAL x4 to 0x220.
E 00000200 01 1 00000005
E 00000204 02 1 12345000
E 00000208 02 1 12345678
E 0000020C 00 0 00000000
E 00000210 03 1 00000001
E 00000214 04 1 00000218
E 00000220 05 1 00000003
E 00000224 06 1 00000000
# BNE loop over three iterations.
E 00000228 06 1 00000002
E 0000022C 05 1 00000002
E 00000230 00 0 00000000
E 00000228 06 1 00000004
E 0000022C 05 1 00000001
E 00000230 00 0 00000000
E 00000228 06 1 00000006
E 0000022C 05 1 00000000
E 00000230 00 0 00000000
# BEQ falls through, BEQ jumps over 0x23C, then JAL x1 to 0x24E.
E 00000234 00 0 00000000
E 00000238 00 0 00000000
E 00000240 07 1 ABCDE000
E 00000244 08 1 ABCDDFFF
E 00000248 01 1 0000024C
F 0000024E

// ==== flist.f ====
source/fe_pkg.sv
source/fetch_stage.sv
source/branch_predictor.sv
source/hazard_unit.sv
source/instr_ram.sv
source/execute_stage.sv
source/fetch_exec_top.sv
bench/tb_fetch_exec.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_fetch_exec
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
